/* common/periph_pkg.sv */
/*
 * Shared definitions for the peripheral register bus
 * Host bus widths, region codes, DSP operand select,
 * status LED type and flash bit-bang control fields
 */
`default_nettype none

package periph_pkg;

    // Host bus
    typedef logic [23:0] bus_addr_t;
    typedef logic [31:0] bus_data_t;
    typedef logic [3:0] bus_wstrb_t;

    // Region code taken from the top address nibble
    typedef logic [3:0] region_t;
    localparam int REGION_LSB = 20;

    localparam region_t REGION_STATUS = 4'd1;
    localparam region_t REGION_DSP = 4'd2;
    localparam region_t REGION_PAD = 4'd3;
    localparam region_t REGION_FLASH = 4'd4;

    // Address bit picking operand B over operand A
    localparam int DSP_SEL_BIT = 2;

    // Bit 0 drives led_r and bit 1 drives led_b
    typedef logic [1:0] led_status_t;
    localparam led_status_t STATUS_RESET = 2'b01;

    // Four flash data lines
    typedef logic [3:0] flash_nibble_t;

    // Flash control fields in the write data
    localparam int FLASH_DOUT_LSB = 0;
    localparam int FLASH_OE_LSB = 4;
    localparam int FLASH_CLK_BIT = 8;
    localparam int FLASH_CSN_BIT = 9;
    localparam int FLASH_ACTIVE_BIT = 15;

endpackage

`default_nettype wire

/* hdl/periph_decoder.sv */
/*
 * Request register and address decoder
 * One-hot region selects and write strobes, one cycle after the request
 */
`default_nettype none

module periph_decoder (
    input wire vdp_clk,
    input wire vdp_reset,

    input wire bus_valid,
    input wire periph_pkg::bus_addr_t bus_addr,
    input wire periph_pkg::bus_wstrb_t bus_wstrb,
    input wire periph_pkg::bus_data_t bus_wdata,

    output logic req_valid,
    output logic req_read,
    output periph_pkg::bus_addr_t req_addr,
    output periph_pkg::bus_data_t req_wdata,

    output logic status_sel,
    output logic status_we,
    output logic dsp_sel,
    output logic dsp_we,
    output logic pad_sel,
    output logic pad_we,
    output logic flash_sel,
    output logic flash_we
);
    periph_pkg::region_t req_region;

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            req_valid <= 1'b0;
        end else begin
            req_valid <= bus_valid;
        end
    end

    // Payload only captured with a request
    always_ff @(posedge vdp_clk) begin
        if (bus_valid) begin
            req_addr <= bus_addr;
            req_wdata <= bus_wdata;
            // No strobe bit set means a read
            req_read <= (bus_wstrb == '0);
        end
    end

    assign req_region = req_addr[periph_pkg::REGION_LSB +: $bits(periph_pkg::region_t)];

    assign status_sel = req_valid && (req_region == periph_pkg::REGION_STATUS);
    assign dsp_sel = req_valid && (req_region == periph_pkg::REGION_DSP);
    assign pad_sel = req_valid && (req_region == periph_pkg::REGION_PAD);
    assign flash_sel = req_valid && (req_region == periph_pkg::REGION_FLASH);

    // Write strobes
    assign status_we = status_sel && !req_read;
    assign dsp_we = dsp_sel && !req_read;
    assign pad_we = pad_sel && !req_read;
    assign flash_we = flash_sel && !req_read;

endmodule

`default_nettype wire

/* hdl/dsp_mult.sv */
/*
 * Signed multiplier peripheral
 * Two operand registers and a registered product
 */
`default_nettype none

module dsp_mult #(
    parameter int DSP_W = 16
) (
    input wire vdp_clk,

    input wire dsp_we,
    input wire periph_pkg::bus_addr_t req_addr,
    input wire periph_pkg::bus_data_t req_wdata,

    output periph_pkg::bus_data_t dsp_product
);
    logic signed [DSP_W-1:0] op_a;
    logic signed [DSP_W-1:0] op_b;
    logic signed [2*DSP_W-1:0] product_full;

    logic sel_b;

    assign sel_b = req_addr[periph_pkg::DSP_SEL_BIT];

    // Flat enables so the operands map onto the DSP input registers
    always_ff @(posedge vdp_clk) begin
        if (dsp_we && !sel_b) begin
            op_a <= req_wdata[DSP_W-1:0];
        end

        if (dsp_we && sel_b) begin
            op_b <= req_wdata[DSP_W-1:0];
        end
    end

    assign product_full = op_a * op_b;

    // Output register of the multiplier, sign-extended to bus width
    always_ff @(posedge vdp_clk) begin
        dsp_product <= periph_pkg::bus_data_t'(product_full);
    end

endmodule

`default_nettype wire

/* hdl/pad_reader.sv */
/*
 * Gamepad reader mocked with the three board buttons
 * Software latch and clock bits, button snapshot shifted out serially
 */
`default_nettype none

module pad_reader #(
    parameter int PAD_BITS = 16
) (
    input wire vdp_clk,
    input wire vdp_reset,

    input wire pad_we,
    input wire periph_pkg::bus_data_t req_wdata,

    input wire btn_1,
    input wire btn_2,
    input wire btn_3,

    output periph_pkg::bus_data_t pad_data
);
    logic pad_latch;
    logic pad_clk;
    logic pad_clk_r;
    logic pad_clk_rise;

    logic [PAD_BITS-1:0] pad_load;
    logic [PAD_BITS-1:0] pad_shift;

    // Button positions as a real pad would report them
    always_comb begin
        pad_load = '0;
        pad_load[0] = btn_2;
        pad_load[6] = btn_3;
        pad_load[7] = btn_1;
    end

    assign pad_clk_rise = pad_clk && !pad_clk_r;

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            pad_latch <= 1'b0;
            pad_clk <= 1'b0;
            pad_clk_r <= 1'b0;
            pad_shift <= '0;
        end else begin
            if (pad_we) begin
                pad_latch <= req_wdata[0];
                pad_clk <= req_wdata[1];
            end

            pad_clk_r <= pad_clk;

            // A clock edge wins over a held latch
            if (pad_clk_rise) begin
                pad_shift <= {1'b0, pad_shift[PAD_BITS-1:1]};
            end else if (pad_latch) begin
                pad_shift <= pad_load;
            end
        end
    end

    // Serial data bit
    assign pad_data = periph_pkg::bus_data_t'(pad_shift[0]);

endmodule

`default_nettype wire

/* hdl/sys_ctrl_regs.sv */
/*
 * System control registers
 * Status LED register and flash bit-bang control
 * with sampled flash_out readback
 */
`default_nettype none

module sys_ctrl_regs (
    input wire vdp_clk,
    input wire vdp_reset,

    input wire status_we,
    input wire flash_we,
    input wire periph_pkg::bus_data_t req_wdata,
    input wire periph_pkg::flash_nibble_t flash_out,

    output logic led_r,
    output logic led_b,
    output periph_pkg::bus_data_t status_data,

    output logic flash_clk,
    output logic flash_csn,
    output periph_pkg::flash_nibble_t flash_in,
    output periph_pkg::flash_nibble_t flash_in_en,
    output periph_pkg::bus_data_t flash_data
);
    localparam int NIB_W = $bits(periph_pkg::flash_nibble_t);

    periph_pkg::led_status_t status;

    logic flash_active;
    logic flash_clk_r;
    logic flash_csn_r;
    periph_pkg::flash_nibble_t flash_dout_r;
    periph_pkg::flash_nibble_t flash_oe_r;
    periph_pkg::flash_nibble_t flash_sample;

    // Status LEDs
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            status <= periph_pkg::STATUS_RESET;
        end else if (status_we) begin
            status <= req_wdata[$bits(periph_pkg::led_status_t)-1:0];
        end
    end

    assign led_r = status[0];
    assign led_b = status[1];
    assign status_data = periph_pkg::bus_data_t'(status);

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            flash_active <= 1'b0;
        end else if (flash_we) begin
            flash_active <= req_wdata[periph_pkg::FLASH_ACTIVE_BIT];
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (flash_we) begin
            flash_dout_r <= req_wdata[periph_pkg::FLASH_DOUT_LSB +: NIB_W];
            flash_oe_r <= req_wdata[periph_pkg::FLASH_OE_LSB +: NIB_W];
            flash_clk_r <= req_wdata[periph_pkg::FLASH_CLK_BIT];
            flash_csn_r <= req_wdata[periph_pkg::FLASH_CSN_BIT];
        end
    end

    // Released bus parks with chip deselected and no lines driven
    assign flash_clk = flash_active ? flash_clk_r : 1'b0;
    assign flash_csn = flash_active ? flash_csn_r : 1'b1;
    assign flash_in = flash_active ? flash_dout_r : '0;
    assign flash_in_en = flash_active ? flash_oe_r : '0;

    // Readback of the flash lines, one cycle old
    always_ff @(posedge vdp_clk) begin
        flash_sample <= flash_out;
    end

    assign flash_data = periph_pkg::bus_data_t'(flash_sample);

endmodule

`default_nettype wire

/* hdl/read_mux.sv */
/*
 * Read data mux and response strobe
 * Selected region value registered into bus_rdata with bus_ready
 */
`default_nettype none

module read_mux #(
    parameter int DSP_W = 16
) (
    input wire vdp_clk,
    input wire vdp_reset,

    input wire req_valid,
    input wire req_read,
    input wire status_sel,
    input wire dsp_sel,
    input wire pad_sel,
    input wire flash_sel,

    input wire periph_pkg::bus_data_t status_data,
    input wire periph_pkg::bus_data_t dsp_product,
    input wire periph_pkg::bus_data_t pad_data,
    input wire periph_pkg::bus_data_t flash_data,

    output periph_pkg::bus_data_t bus_rdata,
    output logic bus_ready
);
    localparam int PROD_W = 2 * DSP_W;

    periph_pkg::bus_data_t dsp_value;
    periph_pkg::bus_data_t rd_value;

    // Only the low 2*DSP_W product bits carry information
    assign dsp_value = periph_pkg::bus_data_t'($signed(dsp_product[PROD_W-1:0]));

    // Selects are one-hot, unmapped reads fall through as zero
    always_comb begin
        rd_value = '0;
        if (req_read) begin
            if (status_sel) begin
                rd_value = status_data;
            end else if (dsp_sel) begin
                rd_value = dsp_value;
            end else if (pad_sel) begin
                rd_value = pad_data;
            end else if (flash_sel) begin
                rd_value = flash_data;
            end
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            bus_ready <= 1'b0;
        end else begin
            bus_ready <= req_valid;
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (req_valid) begin
            bus_rdata <= rd_value;
        end
    end

endmodule

`default_nettype wire

/* hdl/periph_top.sv */
/*
 * Peripheral register bus top level
 * Decoder, DSP multiplier, pad reader, system control
 * registers and read mux
 */
`default_nettype none

module periph_top #(
    parameter int DSP_W = 16,
    parameter int PAD_BITS = 16
) (
    input wire vdp_clk,
    input wire vdp_reset,

    input wire bus_valid,
    input wire periph_pkg::bus_addr_t bus_addr,
    input wire periph_pkg::bus_wstrb_t bus_wstrb,
    input wire periph_pkg::bus_data_t bus_wdata,
    output wire periph_pkg::bus_data_t bus_rdata,
    output wire bus_ready,

    output wire led_r,
    output wire led_b,

    input wire btn_1,
    input wire btn_2,
    input wire btn_3,

    output wire flash_clk,
    output wire flash_csn,
    output wire periph_pkg::flash_nibble_t flash_in,
    output wire periph_pkg::flash_nibble_t flash_in_en,
    input wire periph_pkg::flash_nibble_t flash_out
);
    wire req_valid;
    wire req_read;
    periph_pkg::bus_addr_t req_addr;
    periph_pkg::bus_data_t req_wdata;

    wire status_sel;
    wire status_we;
    wire dsp_sel;
    wire dsp_we;
    wire pad_sel;
    wire pad_we;
    wire flash_sel;
    wire flash_we;

    periph_pkg::bus_data_t status_data;
    periph_pkg::bus_data_t dsp_product;
    periph_pkg::bus_data_t pad_data;
    periph_pkg::bus_data_t flash_data;

    // Decode stage
    periph_decoder u_periph_decoder (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .bus_valid(bus_valid),
        .bus_addr(bus_addr),
        .bus_wstrb(bus_wstrb),
        .bus_wdata(bus_wdata),
        .req_valid(req_valid),
        .req_read(req_read),
        .req_addr(req_addr),
        .req_wdata(req_wdata),
        .status_sel(status_sel),
        .status_we(status_we),
        .dsp_sel(dsp_sel),
        .dsp_we(dsp_we),
        .pad_sel(pad_sel),
        .pad_we(pad_we),
        .flash_sel(flash_sel),
        .flash_we(flash_we)
    );

    // Execute stage
    dsp_mult #(
        .DSP_W(DSP_W)
    ) u_dsp_mult (
        .vdp_clk(vdp_clk),
        .dsp_we(dsp_we),
        .req_addr(req_addr),
        .req_wdata(req_wdata),
        .dsp_product(dsp_product)
    );

    pad_reader #(
        .PAD_BITS(PAD_BITS)
    ) u_pad_reader (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .pad_we(pad_we),
        .req_wdata(req_wdata),
        .btn_1(btn_1),
        .btn_2(btn_2),
        .btn_3(btn_3),
        .pad_data(pad_data)
    );

    sys_ctrl_regs u_sys_ctrl_regs (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .status_we(status_we),
        .flash_we(flash_we),
        .req_wdata(req_wdata),
        .flash_out(flash_out),
        .led_r(led_r),
        .led_b(led_b),
        .status_data(status_data),
        .flash_clk(flash_clk),
        .flash_csn(flash_csn),
        .flash_in(flash_in),
        .flash_in_en(flash_in_en),
        .flash_data(flash_data)
    );

    // Result stage
    read_mux #(
        .DSP_W(DSP_W)
    ) u_read_mux (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .req_valid(req_valid),
        .req_read(req_read),
        .status_sel(status_sel),
        .dsp_sel(dsp_sel),
        .pad_sel(pad_sel),
        .flash_sel(flash_sel),
        .status_data(status_data),
        .dsp_product(dsp_product),
        .pad_data(pad_data),
        .flash_data(flash_data),
        .bus_rdata(bus_rdata),
        .bus_ready(bus_ready)
    );

endmodule

`default_nettype wire

/* verif/periph_props.sv */
/*
 * Concurrent assertions on response timing
 * and flash idle levels, bound into periph_top
 */
`default_nettype none

module periph_props (
    input wire vdp_clk,
    input wire vdp_reset,
    input wire bus_valid,
    input wire bus_ready,
    input wire flash_active,
    input wire flash_clk,
    input wire flash_csn,
    input wire periph_pkg::flash_nibble_t flash_in,
    input wire periph_pkg::flash_nibble_t flash_in_en
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    // Every request answered two cycles later
    ready_latency: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        bus_valid |-> ##2 bus_ready
    ) else begin
        $error("bus_ready does not follow bus_valid by two cycles");
        fail_count++;
    end

    // Ready held over two cycles only behind back-to-back requests
    ready_single: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        bus_ready |=> !bus_ready || $past(bus_valid, 2)
    ) else begin
        $error("bus_ready high in consecutive cycles without a second request");
        fail_count++;
    end

    flash_idle: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        !flash_active |-> flash_csn && !flash_clk && flash_in == '0 && flash_in_en == '0
    ) else begin
        $error("flash lines not idle while inactive");
        fail_count++;
    end

endmodule

bind periph_top periph_props u_periph_props (
    .vdp_clk(vdp_clk),
    .vdp_reset(vdp_reset),
    .bus_valid(bus_valid),
    .bus_ready(bus_ready),
    .flash_active(u_sys_ctrl_regs.flash_active),
    .flash_clk(flash_clk),
    .flash_csn(flash_csn),
    .flash_in(flash_in),
    .flash_in_en(flash_in_en)
);

`default_nettype wire

/* verif/periph_tb.sv */
/*
 * Testbench for the peripheral register bus
 * Host request tasks, register model, response compare process and report
 */
`default_nettype none

module periph_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int DSP_W = 16;
    localparam int PAD_BITS = 16;
    localparam int RSP_TIMEOUT = 20;
    localparam periph_pkg::region_t UNMAPPED[4] = '{4'h0, 4'h5, 4'h9, 4'hf};

    typedef struct {
        logic signed [DSP_W-1:0] op_a;
        logic signed [DSP_W-1:0] op_b;
        periph_pkg::led_status_t status;
        periph_pkg::flash_nibble_t flash_out;
        logic [PAD_BITS-1:0] pad_reg;
    } model_state_t;

    logic vdp_clk;
    logic vdp_reset;
    logic bus_valid;
    periph_pkg::bus_addr_t bus_addr;
    periph_pkg::bus_wstrb_t bus_wstrb;
    periph_pkg::bus_data_t bus_wdata;
    periph_pkg::bus_data_t bus_rdata;
    logic bus_ready;
    logic led_r;
    logic led_b;
    logic btn_1;
    logic btn_2;
    logic btn_3;
    logic flash_clk;
    logic flash_csn;
    periph_pkg::flash_nibble_t flash_in;
    periph_pkg::flash_nibble_t flash_in_en;
    periph_pkg::flash_nibble_t flash_out;

    model_state_t st;
    periph_pkg::bus_data_t exp_q[$];
    bit chk_q[$];
    periph_pkg::bus_data_t rsp_exp;
    bit rsp_chk;
    int seed = 32'h4c81;
    int req_count = 0;
    int rsp_count = 0;
    int err_count = 0;
    int check_count = 0;
    int test_count = 0;
    int test_err_base = 0;

    periph_top #(
        .DSP_W(DSP_W),
        .PAD_BITS(PAD_BITS)
    ) u_periph_top (.*);

    initial begin
        vdp_clk = 1'b0;
        forever #20 vdp_clk = ~vdp_clk;
    end

    function automatic periph_pkg::bus_addr_t addr_of(periph_pkg::region_t region, int offset);
        return {region, 20'(offset)};
    endfunction

    // Expected read data from the register model
    function automatic periph_pkg::bus_data_t model_read(periph_pkg::bus_addr_t addr,
                                                         model_state_t s);
        logic signed [31:0] ext_a;
        logic signed [31:0] ext_b;
        ext_a = s.op_a;
        ext_b = s.op_b;
        case (addr[23:20])
            periph_pkg::REGION_STATUS: return {30'd0, s.status};
            periph_pkg::REGION_DSP: return ext_a * ext_b;
            periph_pkg::REGION_PAD: return {31'd0, s.pad_reg[0]};
            periph_pkg::REGION_FLASH: return {28'd0, s.flash_out};
            default: return '0;
        endcase
    endfunction

    task automatic check_data(input periph_pkg::bus_data_t got, input periph_pkg::bus_data_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("[ERROR] %0t: bus_rdata 0x%08h, expected 0x%08h", $time, got, exp);
        end
    endtask

    task automatic check_status(input periph_pkg::led_status_t got,
                                input periph_pkg::led_status_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("[ERROR] %0t: LEDs {b,r} %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic check_flash_pins(input periph_pkg::flash_nibble_t got_in,
                                    input periph_pkg::flash_nibble_t got_en,
                                    input logic got_clk, input logic got_csn,
                                    input periph_pkg::flash_nibble_t exp_in,
                                    input periph_pkg::flash_nibble_t exp_en,
                                    input logic exp_clk, input logic exp_csn);
        check_count++;
        if ({got_in, got_en, got_clk, got_csn} !== {exp_in, exp_en, exp_clk, exp_csn}) begin
            err_count++;
            $display("[ERROR] %0t: flash in %h en %h clk %b csn %b, expected %h %h %b %b",
                     $time, got_in, got_en, got_clk, got_csn, exp_in, exp_en, exp_clk, exp_csn);
        end
    endtask

    // Responses are taken in request order, sampled mid-cycle
    always @(negedge vdp_clk) begin
        if (!vdp_reset && bus_ready) begin
            if (exp_q.size() == 0) begin
                err_count++;
                $display("bus_ready seen at %0t with no request outstanding", $time);
            end else begin
                rsp_exp = exp_q.pop_front();
                rsp_chk = chk_q.pop_front();
                rsp_count++;
                if (rsp_chk) begin
                    check_data(bus_rdata, rsp_exp);
                end
            end
        end
    end

    task automatic issue_request(input periph_pkg::bus_addr_t addr,
                                 input periph_pkg::bus_wstrb_t wstrb,
                                 input periph_pkg::bus_data_t wdata);
        @(posedge vdp_clk);
        bus_valid <= 1'b1;
        bus_addr <= addr;
        bus_wstrb <= wstrb;
        bus_wdata <= wdata;
        exp_q.push_back(model_read(addr, st));
        chk_q.push_back(wstrb == '0);
        req_count++;
    endtask

    task automatic end_burst();
        @(posedge vdp_clk);
        bus_valid <= 1'b0;
        bus_wstrb <= '0;
    endtask

    task automatic wait_responses();
        int cycles;
        cycles = 0;
        while (rsp_count != req_count && cycles < RSP_TIMEOUT) begin
            @(posedge vdp_clk);
            cycles++;
        end
        if (rsp_count != req_count) begin
            $display("Timeout: only %0d of %0d requests answered with bus_ready",
                     rsp_count, req_count);
            $display("TB FAILED");
            $finish;
        end
    endtask

    task automatic write_reg(input periph_pkg::bus_addr_t addr, input periph_pkg::bus_data_t data);
        issue_request(addr, 4'hf, data);
        end_burst();
        wait_responses();
    endtask

    task automatic read_reg(input periph_pkg::bus_addr_t addr);
        issue_request(addr, 4'h0, '0);
        end_burst();
        wait_responses();
    endtask

    task automatic finish_test(input string name);
        test_count++;
        if (err_count == test_err_base) begin
            $display("Test %0d %s: ok", test_count, name);
        end else begin
            $display("Test %0d %s: %0d errors", test_count, name, err_count - test_err_base);
        end
        test_err_base = err_count;
    endtask

    initial begin
        logic signed [DSP_W-1:0] opnd_a;
        logic signed [DSP_W-1:0] opnd_b;
        logic [PAD_BITS-1:0] load;
        logic btn3_level;
        periph_pkg::bus_data_t wdata;
        periph_pkg::flash_nibble_t nib;

        vdp_reset = 1'b1;
        bus_valid = 1'b0;
        bus_addr = '0;
        bus_wstrb = '0;
        bus_wdata = '0;
        btn_1 = 1'b0;
        btn_2 = 1'b0;
        btn_3 = 1'b0;
        flash_out = '0;
        st = '{op_a: '0, op_b: '0, status: 2'b01, flash_out: '0, pad_reg: '0};
        repeat (5) @(posedge vdp_clk);
        vdp_reset <= 1'b0;

        check_status({led_b, led_r}, 2'b01);
        read_reg(addr_of(periph_pkg::REGION_STATUS, 0));
        repeat (3) begin
            wdata = $random(seed);
            write_reg(addr_of(periph_pkg::REGION_STATUS, 0), wdata);
            st.status = wdata[1:0];
            check_status({led_b, led_r}, st.status);
            read_reg(addr_of(periph_pkg::REGION_STATUS, 0));
        end
        finish_test("status LEDs");

        // Operand B sits at the address with bit 2 set
        for (int i = 0; i < 20; i++) begin
            opnd_a = (i < 2) ? 16'sh8000 : DSP_W'($random(seed));
            opnd_b = (i == 0) ? 16'sh8000 : (i == 1) ? 16'sh7fff : DSP_W'($random(seed));
            issue_request(addr_of(periph_pkg::REGION_DSP, 0), 4'hf, 32'(opnd_a));
            st.op_a = opnd_a;
            issue_request(addr_of(periph_pkg::REGION_DSP, 4), 4'hf, 32'(opnd_b));
            st.op_b = opnd_b;
            end_burst();
            read_reg(addr_of(periph_pkg::REGION_DSP, 0));
        end
        finish_test("signed multiplier");

        btn3_level = 1'($random(seed));
        @(posedge vdp_clk);
        btn_1 <= 1'b1;
        btn_2 <= 1'b1;
        btn_3 <= btn3_level;
        load = '0;
        load[0] = 1'b1;
        load[7] = 1'b1;
        load[6] = btn3_level;
        write_reg(addr_of(periph_pkg::REGION_PAD, 0), 32'h1);
        write_reg(addr_of(periph_pkg::REGION_PAD, 0), 32'h0);
        st.pad_reg = load;
        for (int i = 0; i < 10; i++) begin
            read_reg(addr_of(periph_pkg::REGION_PAD, 0));
            write_reg(addr_of(periph_pkg::REGION_PAD, 0), 32'h2);
            st.pad_reg = st.pad_reg >> 1;
            write_reg(addr_of(periph_pkg::REGION_PAD, 0), 32'h0);
        end
        finish_test("pad shift register");

        repeat (3) begin
            wdata = $random(seed);
            wdata[periph_pkg::FLASH_ACTIVE_BIT] = 1'b1;
            write_reg(addr_of(periph_pkg::REGION_FLASH, 0), wdata);
            check_flash_pins(flash_in, flash_in_en, flash_clk, flash_csn, wdata[3:0],
                             wdata[7:4], wdata[periph_pkg::FLASH_CLK_BIT],
                             wdata[periph_pkg::FLASH_CSN_BIT]);
            wdata[periph_pkg::FLASH_ACTIVE_BIT] = 1'b0;
            write_reg(addr_of(periph_pkg::REGION_FLASH, 0), wdata);
            check_flash_pins(flash_in, flash_in_en, flash_clk, flash_csn, '0, '0, 1'b0, 1'b1);
            nib = 4'($random(seed));
            @(posedge vdp_clk);
            flash_out <= nib;
            st.flash_out = nib;
            read_reg(addr_of(periph_pkg::REGION_FLASH, 0));
        end
        finish_test("flash bit-bang");

        // Back-to-back burst mixing mapped and unmapped regions
        issue_request(addr_of(periph_pkg::REGION_STATUS, 0), 4'hf, 32'h2);
        st.status = 2'b10;
        issue_request(addr_of(periph_pkg::REGION_STATUS, 0), 4'h0, '0);
        issue_request(addr_of(4'h0, 'h10), 4'h0, '0);
        issue_request(addr_of(4'h5, 0), 4'hf, $random(seed));
        issue_request(addr_of(4'hf, 'h8), 4'h0, '0);
        issue_request(addr_of(periph_pkg::REGION_DSP, 0), 4'h0, '0);
        issue_request(addr_of(periph_pkg::REGION_FLASH, 0), 4'h0, '0);
        end_burst();
        wait_responses();
        foreach (UNMAPPED[i]) begin
            write_reg(addr_of(UNMAPPED[i], $random(seed) & 'hffffc), $random(seed));
            read_reg(addr_of(UNMAPPED[i], 0));
        end
        read_reg(addr_of(periph_pkg::REGION_STATUS, 0));
        read_reg(addr_of(periph_pkg::REGION_DSP, 0));
        read_reg(addr_of(periph_pkg::REGION_PAD, 0));
        read_reg(addr_of(periph_pkg::REGION_FLASH, 0));
        check_status({led_b, led_r}, st.status);
        check_flash_pins(flash_in, flash_in_en, flash_clk, flash_csn, '0, '0, 1'b0, 1'b1);
        finish_test("burst and unmapped");

        err_count += u_periph_top.u_periph_props.fail_count;
        $display("Tests %0d, checks %0d, requests %0d, responses %0d, errors %0d",
                 test_count, check_count, req_count, rsp_count, err_count);
        if (err_count == 0 && exp_q.size() == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
common/periph_pkg.sv
hdl/periph_decoder.sv
hdl/dsp_mult.sv
hdl/pad_reader.sv
hdl/sys_ctrl_regs.sv
hdl/read_mux.sv
hdl/periph_top.sv
verif/periph_props.sv
verif/periph_tb.sv

/* Makefile */
# Verilator build and run of the peripheral bus testbench

SIM       := verilator
TOP       := periph_tb
FILELIST  := list.f
SIMFLAGS  := --binary --timing --assert -Wno-fatal
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q '^TB PASSED$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
